// File: tb.f
hdl/mcpu_pkg.sv
hdl/mcpu_sync.sv
hdl/mcpu_reset_ctrl.sv
hdl/mcpu_mem_ctrl.sv
hdl/mcpu_int.sv
hdl/mcpu.sv
bench/tb_clock.sv
bench/tb_mcpu.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= tb.f
TB_TOP     ?= tb_mcpu
RTL_TOP    ?= mcpu
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -j 0

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter hdl/%,$(SRCS))
BIN      := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(SIM_FLAGS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_mcpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mcpu;

  import mcpu_pkg::*;

  localparam int SYNC_STAGES  = 2;
  localparam int UART_STAGES  = 4;                  // Serial line sync depth
  localparam int MEM_AW       = 8;
  localparam int INIT_CYCLES  = 16;
  localparam int READ_LATENCY = 3;
  localparam int PERIOD_NS    = 100;
  localparam int N_MEM        = 2000;
  localparam int N_LED        = 200;
  localparam int N_IO         = 300;                // Memory and input read pairs
  localparam int N_KEEP       = 32;                 // Readbacks after key reset
  localparam int N_OPS        = N_MEM + N_LED + 2 * N_IO + N_KEEP;
  localparam longint TIMEOUT_NS = longint'(INIT_CYCLES + 20 + 4 * N_OPS) * PERIOD_NS;

  logic       clk50;
  logic       arst_n;
  logic [9:0] sw;
  logic [3:0] key;
  logic       uart_rx;
  avl_req_t   host_req;
  logic       host_ready;
  avl_rsp_t   host_rsp;
  logic [9:0] ledr;
  logic [7:0] ledg;
  logic       mc_ready;

  // Reference model state
  avl_data_t                     model_mem [2**MEM_AW];
  logic [SYNC_STAGES-1:0][9:0]   sw_pipe;
  logic [SYNC_STAGES-1:0][3:0]   btn_pipe;          // Inverted keys
  logic [UART_STAGES-1:0]        rx_pipe;
  logic [9:0]                    ledr_exp;
  logic [7:0]                    ledg_exp;
  logic                          led_check;
  avl_data_t                     exp_data [$];      // In acceptance order
  int                            exp_due [$];       // Cycle each response is due
  int                            cycle_cnt;

  tb_clock #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(2)) u_clock (
    .clk50 (clk50),
    .arst_n(arst_n)
  );

  mcpu #(
    .SYNC_STAGES (SYNC_STAGES),
    .MEM_AW      (MEM_AW),
    .INIT_CYCLES (INIT_CYCLES),
    .READ_LATENCY(READ_LATENCY)
  ) i_mcpu (
    .clk50     (clk50),
    .arst_n    (arst_n),
    .sw        (sw),
    .key       (key),
    .uart_rx   (uart_rx),
    .host_req  (host_req),
    .host_ready(host_ready),
    .host_rsp  (host_rsp),
    .ledr      (ledr),
    .ledg      (ledg),
    .mc_ready  (mc_ready)
  );

  // Inputs settle SYNC_STAGES edges later and the serial line after 4
  always @(posedge clk50 or negedge arst_n) begin
    if (!arst_n) begin
      sw_pipe  <= '0;
      btn_pipe <= '0;
      rx_pipe  <= '0;
    end else begin
      sw_pipe  <= {sw_pipe[SYNC_STAGES-2:0], sw};
      btn_pipe <= {btn_pipe[SYNC_STAGES-2:0], ~key};
      rx_pipe  <= {rx_pipe[UART_STAGES-2:0], uart_rx};
    end
  end

  task automatic value_error(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    $display("error: time %0t, signal %s, expected %0h, actual %0h", $time, name, exp, act);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("time %0t: %s", $time, what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  function automatic avl_data_t rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic avl_req_t mem_access(input logic wr);
    avl_req_t r;
    r      = '0;
    r.addr = {1'b0, 24'($urandom)};                 // Upper bits alias
    if ($urandom_range(1, 0) == 0) begin
      r.addr[MEM_AW-1:0] = MEM_AW'($urandom_range(15, 0));  // Crowd a few lines
    end
    r.be         = 16'($urandom);
    r.wdata      = rand_line();
    r.write_req  = wr;
    r.read_req   = !wr;
    r.burstbegin = 1'b1;
    r.size       = 5'd1;
    return r;
  endfunction

  function automatic avl_req_t io_access(input logic wr, input logic [23:0] word);
    avl_req_t r;
    r            = mem_access(wr);
    r.addr       = {1'b1, word};
    return r;
  endfunction

  // Response order and latency plus LED state
  task automatic check_outputs();
    avl_data_t d;
    int        due;
    if (cycle_cnt >= INIT_CYCLES) begin
      assert (mc_ready == 1'b1) else value_error("mc_ready", 1, mc_ready);
    end
    if (host_rsp.rdata_valid) begin
      assert (exp_due.size() > 0) else abort_run("rdata_valid with no read outstanding");
      d   = exp_data.pop_front();
      due = exp_due.pop_front();
      assert (cycle_cnt == due) else value_error("rdata_valid cycle", due, cycle_cnt);
      assert (host_rsp.rdata == d) else value_error("host_rsp.rdata", d, host_rsp.rdata);
    end else if (exp_due.size() > 0) begin
      assert (exp_due[0] > cycle_cnt) else abort_run("read response missing at its cycle");
    end
    if (led_check) begin
      assert (ledr == ledr_exp) else value_error("ledr", ledr_exp, ledr);
      assert (ledg == ledg_exp) else value_error("ledg", ledg_exp, ledg);
    end
  endtask

  // Sample 1 ns after the edge and change the inputs at the drive point
  task automatic tick();
    @(posedge clk50);
    #1;
    cycle_cnt++;
    check_outputs();
    #9;
    wiggle_inputs();
  endtask

  task automatic accept(input avl_req_t r);
    avl_data_t               rd;
    logic [IO_SPACE_BIT-1:0] word;
    logic [MEM_AW-1:0]       idx;
    word = r.addr[IO_SPACE_BIT-1:0];
    idx  = r.addr[MEM_AW-1:0];
    if (!r.addr[IO_SPACE_BIT]) begin
      if (r.write_req) begin
        for (int b = 0; b < 16; b++) begin
          if (r.be[b]) begin
            model_mem[idx][8*b +: 8] = r.wdata[8*b +: 8];
          end
        end
      end else begin
        exp_data.push_back(model_mem[idx]);
        exp_due.push_back(cycle_cnt + READ_LATENCY);
      end
    end else if (r.write_req) begin
      if (word == IO_LED_ADDR && r.be[2:0] == 3'b111) begin  // Other words ignored
        ledr_exp = r.wdata[9:0];
        ledg_exp = r.wdata[23:16];
      end
    end else begin
      rd = '0;
      if (word == IO_INPUT_ADDR) begin
        rd[9:0]   = sw_pipe[SYNC_STAGES-1];
        rd[19:16] = btn_pipe[SYNC_STAGES-1];
        rd[24]    = rx_pipe[UART_STAGES-1];
      end
      exp_data.push_back(rd);
      exp_due.push_back(cycle_cnt + 1);             // I/O answers next cycle
    end
  endtask

  // Hold the request until host_ready is seen before an edge
  task automatic issue(input avl_req_t r);
    int   waits;
    logic acc;
    waits    = 0;
    acc      = 1'b0;
    host_req = r;
    while (!acc) begin
      #1;
      acc = host_ready;
      if (acc) begin
        accept(r);
      end
      assert (waits < 64) else abort_run("request not accepted within 64 cycles");
      waits++;
      tick();
    end
  endtask

  task automatic idle_cycles(input int n);
    host_req      = '0;
    host_req.size = 5'd1;
    repeat (n) tick();
  endtask

  task automatic drain();
    int waits;
    waits = 0;
    idle_cycles(1);
    while (exp_due.size() > 0) begin
      assert (waits < 32) else abort_run("outstanding reads never completed");
      waits++;
      tick();
    end
  endtask

  task automatic wait_ready(input int limit);
    int waits;
    waits = 0;
    while (!host_ready) begin
      assert (waits < limit) else abort_run("host_ready did not rise");
      waits++;
      tick();
    end
  endtask

  task automatic wiggle_inputs();
    sw       = 10'($urandom);
    key[3:1] = 3'($urandom);                        // Key 0 left alone
    uart_rx  = 1'($urandom);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the tests did not complete", TIMEOUT_NS);
    $display("Testbench failed");
    $fatal(1);
  end

  initial begin
    int       n_init;
    avl_req_t r;
    void'($urandom(32'hb5dc8e0f));
    sw            = '0;
    key           = 4'hf;                           // All released
    uart_rx       = 1'b1;                           // Line idle
    host_req      = '0;
    host_req.size = 5'd1;
    ledr_exp      = '0;
    ledg_exp      = '0;
    led_check     = 1'b1;
    cycle_cnt     = 0;
    foreach (model_mem[i]) model_mem[i] = '0;

    // Init period up to core release
    @(posedge arst_n);
    n_init = 0;
    while (!mc_ready) begin
      assert (host_ready == 1'b0) else value_error("host_ready", 0, host_ready);
      assert (n_init <= INIT_CYCLES) else abort_run("mc_ready stuck low");
      tick();
      n_init++;
    end
    assert (n_init == INIT_CYCLES) else value_error("mc_ready rise cycle", INIT_CYCLES, n_init);
    assert (host_ready == 1'b0) else value_error("host_ready", 0, host_ready);
    wait_ready(8);

    for (int i = 0; i < N_MEM; i++) begin
      issue(mem_access(1'($urandom_range(1, 0))));  // Back to back
    end
    drain();

    for (int i = 0; i < N_LED; i++) begin
      r = io_access(1'b1, ($urandom_range(3, 0) == 0) ? 24'($urandom_range(7, 1)) : IO_LED_ADDR);
      if ($urandom_range(1, 0) == 0) begin
        r.be[2:0] = 3'b111;
      end
      issue(r);
    end

    // Input reads stall behind memory reads
    for (int i = 0; i < N_IO; i++) begin
      issue(mem_access(1'b0));
      issue(io_access(1'b0, ($urandom_range(3, 0) == 0) ? 24'($urandom_range(9, 0))
                                                       : IO_INPUT_ADDR));
    end
    drain();

    // Key 0 resets the core but not the memory
    led_check = 1'b0;
    key[0]    = 1'b0;
    tick();
    tick();
    assert (host_ready == 1'b0) else value_error("host_ready", 0, host_ready);
    assert (ledr == '0) else value_error("ledr", 0, ledr);
    assert (ledg == '0) else value_error("ledg", 0, ledg);
    ledr_exp  = '0;
    ledg_exp  = '0;
    led_check = 1'b1;
    idle_cycles(4);
    key[0] = 1'b1;
    wait_ready(8);
    for (int i = 0; i < N_KEEP; i++) begin
      issue(mem_access(1'b0));
    end
    drain();

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 2
) (
  output logic clk50,
  output logic arst_n
);

  initial begin
    clk50 = 1'b0;
    forever #(PERIOD_NS / 2) clk50 = ~clk50;
  end

  // Release lands on the stimulus offset, away from the edge
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk50);
    #10 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/mcpu.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu #(
  parameter int SYNC_STAGES  = 2,
  parameter int MEM_AW       = 8,
  parameter int INIT_CYCLES  = 16,
  parameter int READ_LATENCY = 3
) (
  input  wire                clk50,
  input  wire                arst_n,
  input  wire  [9:0]         sw,
  input  wire  [3:0]         key,                   // Active low
  input  wire                uart_rx,
  input  wire mcpu_pkg::avl_req_t host_req,
  output logic               host_ready,
  output mcpu_pkg::avl_rsp_t host_rsp,
  output logic [9:0]         ledr,
  output logic [7:0]         ledg,
  output logic               mc_ready
);

  import mcpu_pkg::*;

  localparam int UART_SYNC_STAGES = 4;              // Extra settling on the serial line

  wire io_in_t   io_in;                             // Each member from its own sync
  wire           core_rst_n;
  wire avl_req_t mem_req;
  wire           mem_ready;
  wire avl_rsp_t mem_rsp;

  mcpu_sync #(.payload_t(logic [9:0]), .SYNC_STAGES(SYNC_STAGES)) u_sync_sw (
    .clk50 (clk50),
    .arst_n(arst_n),
    .d     (sw),
    .q     (io_in.switches)
  );

  mcpu_sync #(.payload_t(logic [3:0]), .SYNC_STAGES(SYNC_STAGES)) u_sync_key (
    .clk50 (clk50),
    .arst_n(arst_n),
    .d     (~key),                                  // Pressed reads as 1
    .q     (io_in.buttons)
  );

  mcpu_sync #(.payload_t(logic), .SYNC_STAGES(UART_SYNC_STAGES)) u_sync_rx (
    .clk50 (clk50),
    .arst_n(arst_n),
    .d     (uart_rx),
    .q     (io_in.uart_rx)
  );

  mcpu_reset_ctrl u_rst (
    .clk50     (clk50),
    .arst_n    (arst_n),
    .mc_ready  (mc_ready),
    .key0_n    (key[0]),                            // Key 0 doubles as core reset
    .core_rst_n(core_rst_n)
  );

  mcpu_int u_int (
    .clk50     (clk50),
    .core_rst_n(core_rst_n),
    .host_req  (host_req),
    .host_ready(host_ready),
    .host_rsp  (host_rsp),
    .io_in     (io_in),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_rsp   (mem_rsp),
    .ledr      (ledr),
    .ledg      (ledg)
  );

  // Memory stays on the board reset so contents survive a key reset
  mcpu_mem_ctrl #(
    .MEM_AW      (MEM_AW),
    .INIT_CYCLES (INIT_CYCLES),
    .READ_LATENCY(READ_LATENCY)
  ) u_mc (
    .clk50   (clk50),
    .arst_n  (arst_n),
    .req     (mem_req),
    .ready   (mem_ready),
    .rsp     (mem_rsp),
    .mc_ready(mc_ready)
  );

endmodule

`default_nettype wire

// File: hdl/mcpu_int.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_int (
  input  wire                clk50,
  input  wire                core_rst_n,
  input  wire mcpu_pkg::avl_req_t host_req,
  output logic               host_ready,
  output mcpu_pkg::avl_rsp_t host_rsp,
  input  wire mcpu_pkg::io_in_t   io_in,
  output mcpu_pkg::avl_req_t mem_req,
  input  wire                mem_ready,
  input  wire mcpu_pkg::avl_rsp_t mem_rsp,
  output logic [9:0]         ledr,
  output logic [7:0]         ledg
);

  import mcpu_pkg::*;

  logic                    core_up;                 // Low through core reset
  logic                    is_io;
  logic [IO_SPACE_BIT-1:0] io_word;
  logic                    io_stall;
  logic                    acc;
  logic                    io_rd_acc;
  logic                    io_wr_acc;
  logic                    mem_rd_acc;
  logic [7:0]              rd_pending;              // Memory reads in flight
  avl_data_t               io_rd_line;
  avl_data_t               io_rdata;
  logic                    io_rvalid;

  // First cycle after core reset release
  always_ff @(posedge clk50 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      core_up <= 1'b0;
    end else begin
      core_up <= 1'b1;
    end
  end

  assign is_io   = host_req.addr[IO_SPACE_BIT];
  assign io_word = host_req.addr[IO_SPACE_BIT-1:0];

  // An I/O read would overtake memory reads still in flight
  assign io_stall = host_req.read_req & (rd_pending != '0);

  assign host_ready = core_up & (is_io ? ~io_stall : mem_ready);
  assign acc        = host_ready & (host_req.read_req | host_req.write_req);
  assign io_rd_acc  = acc & is_io & host_req.read_req;
  assign io_wr_acc  = acc & is_io & host_req.write_req;
  assign mem_rd_acc = acc & ~is_io & host_req.read_req;

  // Memory path is combinational, only the strobes are steered
  always_comb begin
    mem_req           = host_req;
    mem_req.read_req  = host_req.read_req & ~is_io & core_up;
    mem_req.write_req = host_req.write_req & ~is_io & core_up;
  end

  always_ff @(posedge clk50 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      rd_pending <= '0;
    end else begin
      case ({mem_rd_acc, mem_rsp.rdata_valid})
        2'b10: rd_pending <= rd_pending + 1'b1;
        2'b01: begin
          if (rd_pending != '0) begin               // Reads issued before a key reset
            rd_pending <= rd_pending - 1'b1;
          end
        end
        default: rd_pending <= rd_pending;          // Both or neither
      endcase
    end
  end

  // Input word layout, unmapped words read as zero
  always_comb begin
    io_rd_line = '0;
    if (io_word == IO_INPUT_ADDR) begin
      io_rd_line[9:0]   = io_in.switches;
      io_rd_line[19:16] = io_in.buttons;
      io_rd_line[24]    = io_in.uart_rx;
    end
  end

  // LED register, needs byte lanes 0 to 2 all enabled
  always_ff @(posedge clk50 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      ledr <= '0;
      ledg <= '0;
    end else if (io_wr_acc && io_word == IO_LED_ADDR && &host_req.be[2:0]) begin
      ledr <= host_req.wdata[9:0];
      ledg <= host_req.wdata[23:16];
    end
  end

  // I/O read answers one cycle after accept
  always_ff @(posedge clk50 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      io_rvalid <= 1'b0;
    end else begin
      io_rvalid <= io_rd_acc;
    end
  end

  always_ff @(posedge clk50) begin
    if (io_rd_acc) begin
      io_rdata <= io_rd_line;
    end
  end

  // Merge, at most one source per cycle
  assign host_rsp.rdata       = io_rvalid ? io_rdata : mem_rsp.rdata;
  assign host_rsp.rdata_valid = io_rvalid | mem_rsp.rdata_valid;

  // Stall logic has to keep the two sources apart
  a_rsp_excl: assert property (
    @(posedge clk50) disable iff (!core_rst_n)
    !(io_rvalid && mem_rsp.rdata_valid)
  ) else $error("mcpu_int: I/O and memory response in the same cycle");

endmodule

`default_nettype wire

// File: hdl/mcpu_mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_mem_ctrl #(
  parameter int MEM_AW       = 8,
  parameter int INIT_CYCLES  = 16,
  parameter int READ_LATENCY = 3
) (
  input  wire                clk50,
  input  wire                arst_n,
  input  wire mcpu_pkg::avl_req_t req,
  output logic               ready,
  output mcpu_pkg::avl_rsp_t rsp,
  output logic               mc_ready
);

  import mcpu_pkg::*;

  localparam int DEPTH = 2 ** MEM_AW;
  localparam int CW    = $clog2(INIT_CYCLES + 1);   // Init counter width

  logic [CW-1:0]          init_cnt;
  logic [MEM_AW-1:0]      idx;                      // Upper addr bits alias
  logic                   rd_acc;
  logic                   wr_acc;
  avl_data_t              mem [DEPTH] = '{default: '0};
  avl_data_t              rd_data [READ_LATENCY];   // Read pipeline payload
  logic [READ_LATENCY-1:0] rd_vld;

  // Init countdown and a sticky mc_ready
  always_ff @(posedge clk50 or negedge arst_n) begin
    if (!arst_n) begin
      init_cnt <= CW'(INIT_CYCLES - 1);
      mc_ready <= 1'b0;
    end else if (!mc_ready) begin
      if (init_cnt == '0) begin
        mc_ready <= 1'b1;                           // Edge INIT_CYCLES after release
      end else begin
        init_cnt <= init_cnt - 1'b1;
      end
    end
  end

  assign ready  = mc_ready;                         // No other back-pressure
  assign idx    = req.addr[MEM_AW-1:0];
  assign rd_acc = req.read_req & mc_ready;
  assign wr_acc = req.write_req & mc_ready;

  // Byte merge under be for the next read to see
  always_ff @(posedge clk50) begin
    if (wr_acc) begin
      for (int b = 0; b < $bits(avl_be_t); b++) begin
        if (req.be[b]) begin
          mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  // Data side of the pipe
  always_ff @(posedge clk50) begin
    rd_data[0] <= mem[idx];                         // Captured at accept edge
    for (int i = 1; i < READ_LATENCY; i++) begin
      rd_data[i] <= rd_data[i-1];
    end
  end

  // Valid side of the pipe
  always_ff @(posedge clk50 or negedge arst_n) begin
    if (!arst_n) begin
      rd_vld <= '0;
    end else begin
      rd_vld[0] <= rd_acc;
      for (int i = 1; i < READ_LATENCY; i++) begin
        rd_vld[i] <= rd_vld[i-1];
      end
    end
  end

  assign rsp.rdata       = rd_data[READ_LATENCY-1];
  assign rsp.rdata_valid = rd_vld[READ_LATENCY-1];  // READ_LATENCY edges after accept

  a_rd_wr_excl: assert property (
    @(posedge clk50) disable iff (!arst_n)
    !(req.read_req && req.write_req)
  ) else $error("mcpu_mem_ctrl: read_req and write_req together");

  // Bursts are not modelled
  a_single_beat: assert property (
    @(posedge clk50) disable iff (!arst_n)
    (rd_acc || wr_acc) |-> (req.size == 5'd1)
  ) else $error("mcpu_mem_ctrl: size %0d accepted", req.size);

endmodule

`default_nettype wire

// File: hdl/mcpu_reset_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_reset_ctrl (
  input  wire  clk50,
  input  wire  arst_n,                              // Board reset
  input  wire  mc_ready,                            // Memory init done
  input  wire  key0_n,                              // Raw key, low when pressed
  output logic core_rst_n
);

  logic       rst_src_n;                            // All release conditions met
  logic [1:0] rst_sync;

  // Combined release condition, key is still asynchronous here
  assign rst_src_n = arst_n & mc_ready & key0_n;

  // Assert on arst_n at once, otherwise through the 2-flop chain
  always_ff @(posedge clk50 or negedge arst_n) begin
    if (!arst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], rst_src_n};
    end
  end

  assign core_rst_n = rst_sync[1];                  // Release 2 edges after sources

  // Core must never run on a memory that is not up
  // Chain delay means the drop shows 2 edges after mc_ready is sampled low
  a_core_needs_mc: assert property (
    @(posedge clk50) disable iff (!arst_n)
    !mc_ready |-> ##2 !core_rst_n
  ) else $error("mcpu_reset_ctrl: core out of reset without mc_ready");

endmodule

`default_nettype wire

// File: hdl/mcpu_sync.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_sync #(
  parameter type payload_t   = logic,
  parameter int  SYNC_STAGES = 2
) (
  input  wire      clk50,
  input  wire      arst_n,
  input  wire      payload_t d,                     // Asynchronous pin value
  output payload_t q
);

  payload_t chain [SYNC_STAGES];                    // Stage 0 may go metastable

  always_ff @(posedge clk50 or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        chain[i] <= '0;
      end
    end else begin
      chain[0] <= d;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        chain[i] <= chain[i-1];                     // Shift towards q
      end
    end
  end

  assign q = chain[SYNC_STAGES-1];                  // Visible SYNC_STAGES edges later

  // A single flop gives no settling time
  a_min_stages: assert property (@(posedge clk50) SYNC_STAGES >= 2)
    else $error("mcpu_sync: SYNC_STAGES below 2");

endmodule

`default_nettype wire

// File: hdl/mcpu_pkg.sv
`default_nettype none

package mcpu_pkg;

  // Address map
  localparam int IO_SPACE_BIT = 24;                  // Set means I/O, clear means memory

  // I/O word index, the bits below the space bit
  localparam logic [IO_SPACE_BIT-1:0] IO_LED_ADDR   = 'd0;  // ledr 9:0, ledg 23:16
  localparam logic [IO_SPACE_BIT-1:0] IO_INPUT_ADDR = 'd1;  // Switches, buttons, uart_rx

  typedef logic [24:0]  avl_addr_t;                  // Line address, not byte address
  typedef logic [127:0] avl_data_t;                  // One full line
  typedef logic [15:0]  avl_be_t;                    // Byte enables

  // Request side of the memory port
  typedef struct packed {
    avl_addr_t  addr;
    avl_be_t    be;
    avl_data_t  wdata;
    logic       read_req;
    logic       write_req;
    logic       burstbegin;                          // Carried only
    logic [4:0] size;                                // Beats, must be 1
  } avl_req_t;

  // Response side
  typedef struct packed {
    avl_data_t rdata;
    logic      rdata_valid;                          // One pulse per accepted read
  } avl_rsp_t;

  // Conditioned board inputs
  typedef struct packed {
    logic [9:0] switches;
    logic [3:0] buttons;                             // Already inverted, high = pressed
    logic       uart_rx;
  } io_in_t;

endpackage

`default_nettype wire
